/* common/cache_pkg.sv */
package cache_pkg;

  // field widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int LINE_WORDS = 4;
  localparam int TAG_W = 22;
  localparam int INDEX_W = 6;
  localparam int WAY_W = 3;
  localparam int WORD_SEL_W = 2;
  localparam int COUNT_W = 16;

  // address split: tag 31..10, index 9..4, word 3..2
  localparam int TAG_LSB = 10;
  localparam int INDEX_LSB = 4;
  localparam int WORD_SEL_LSB = 2;

  // geometry
  localparam int NUM_WAYS = 8;
  localparam int NUM_SETS = 64;

  // queue depth doubles as initial request credits
  localparam int REQ_DEPTH = 4;
  localparam int RESP_CREDITS = 2;

  localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
  localparam int RESP_CNT_W = $clog2(RESP_CREDITS + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WAY_W-1:0] way_t;

  // 0..3 -> 1, 2, 4, 8 active ways starting at way 0
  typedef logic [1:0] way_mode_t;

  typedef logic [COUNT_W-1:0] count_t;

  typedef enum logic {
    IDLE,
    LOOKUP
  } ctrl_state_t;

endpackage

/* logic/req_queue.sv */
module req_queue (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  logic                 in_write,
  input  cache_pkg::way_mode_t in_ways,
  input  cache_pkg::addr_t     in_addr,
  input  cache_pkg::word_t     in_wdata,
  input  logic                 pop,
  output logic                 head_valid,
  output logic                 head_write,
  output cache_pkg::way_mode_t head_ways,
  output cache_pkg::addr_t     head_addr,
  output cache_pkg::word_t     head_wdata,
  output logic                 credit
);
  import cache_pkg::*;

  logic      write_mem [REQ_DEPTH];
  way_mode_t ways_mem  [REQ_DEPTH];
  addr_t     addr_mem  [REQ_DEPTH];
  word_t     wdata_mem [REQ_DEPTH];

  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0] count;

  function automatic logic [REQ_PTR_W-1:0] next_ptr(input logic [REQ_PTR_W-1:0] ptr);
    return (ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + REQ_PTR_W'(1);
  endfunction

  // no full check, the requester never pushes without a credit
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      write_mem[wr_ptr] <= in_write;
      ways_mem[wr_ptr]  <= in_ways;
      addr_mem[wr_ptr]  <= in_addr;
      wdata_mem[wr_ptr] <= in_wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({in_valid, pop})
        2'b10:   count <= count + REQ_CNT_W'(1);
        2'b01:   count <= count - REQ_CNT_W'(1);
        default: count <= count;
      endcase
      // one credit back per entry taken
      credit <= pop;
    end
  end

  assign head_valid = (count != '0);
  assign head_write = write_mem[rd_ptr];
  assign head_ways  = ways_mem[rd_ptr];
  assign head_addr  = addr_mem[rd_ptr];
  assign head_wdata = wdata_mem[rd_ptr];

endmodule

/* cache/tag_array.sv */
module tag_array (
  input  logic                                      clk,
  input  logic                                      reset,
  input  cache_pkg::index_t                         rd_index,
  input  logic                                      wr_en,
  input  cache_pkg::way_t                           wr_way,
  input  cache_pkg::index_t                         wr_index,
  input  cache_pkg::tag_t                           wr_tag,
  output logic [cache_pkg::NUM_WAYS-1:0]            rd_valid,
  output cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0] rd_tags
);
  import cache_pkg::*;

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  tag_t [NUM_WAYS-1:0]               tag_mem [NUM_SETS];

  logic [NUM_WAYS-1:0] valid_row;
  tag_t [NUM_WAYS-1:0] tag_row;

  // write-first bypass onto the row being read
  always_comb
  begin
    valid_row = valid_q[rd_index];
    tag_row   = tag_mem[rd_index];
    if (wr_en && (wr_index == rd_index))
    begin
      valid_row[wr_way] = 1'b1;
      tag_row[wr_way]   = wr_tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      valid_q  <= '0;
      rd_valid <= '0;
    end
    else
    begin
      if (wr_en)
        valid_q[wr_index][wr_way] <= 1'b1;
      rd_valid <= valid_row;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      tag_mem[wr_index][wr_way] <= wr_tag;
    rd_tags <= tag_row;
  end

endmodule

/* cache/data_array.sv */
module data_array (
  input  logic                                       clk,
  input  cache_pkg::index_t                          rd_index,
  input  logic                                       wr_en,
  input  cache_pkg::way_t                            wr_way,
  input  cache_pkg::index_t                          wr_index,
  input  cache_pkg::line_t                           wr_line,
  output cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] rd_lines
);
  import cache_pkg::*;

  // one row holds the lines of all ways of a set
  line_t [NUM_WAYS-1:0] line_mem [NUM_SETS];

  line_t [NUM_WAYS-1:0] line_row;

  // same-edge write shows up in the read
  always_comb
  begin
    line_row = line_mem[rd_index];
    if (wr_en && (wr_index == rd_index))
      line_row[wr_way] = wr_line;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      line_mem[wr_index][wr_way] <= wr_line;
    rd_lines <= line_row;
  end

endmodule

/* cache/cache_ctrl.sv */
module cache_ctrl (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       head_valid,
  input  logic                                       head_write,
  input  cache_pkg::way_mode_t                       head_ways,
  input  cache_pkg::addr_t                           head_addr,
  input  cache_pkg::word_t                           head_wdata,
  output logic                                       pop,
  input  logic                                       resp_credit,
  output logic                                       resp_valid,
  output logic                                       resp_hit,
  output cache_pkg::word_t                           resp_rdata,
  output cache_pkg::index_t                          rd_index,
  input  logic [cache_pkg::NUM_WAYS-1:0]             tag_rd_valid,
  input  cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0]  tag_rd_tags,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] line_rd,
  output logic                                       tag_wr_en,
  output cache_pkg::way_t                            tag_wr_way,
  output cache_pkg::index_t                          tag_wr_index,
  output cache_pkg::tag_t                            tag_wr_tag,
  output logic                                       data_wr_en,
  output cache_pkg::way_t                            data_wr_way,
  output cache_pkg::index_t                          data_wr_index,
  output cache_pkg::line_t                           data_wr_line,
  output cache_pkg::count_t                          hit_count,
  output cache_pkg::count_t                          miss_count
);
  import cache_pkg::*;

  ctrl_state_t state;

  // request held through the lookup
  logic      req_write_q;
  way_mode_t req_ways_q;
  addr_t     req_addr_q;
  word_t     req_wdata_q;

  logic [RESP_CNT_W-1:0] resp_credits;
  way_t                  rr_ptr;

  tag_t                  req_tag;
  index_t                req_index;
  logic [WORD_SEL_W-1:0] word_sel;
  logic [NUM_WAYS-1:0]   hit_vec;
  logic [NUM_WAYS-1:0]   free_vec;
  way_t                  way_limit;
  way_t                  hit_way;
  way_t                  free_way;
  way_t                  victim_way;
  way_t                  sel_way;
  logic                  hit;
  line_t                 new_line;
  word_t                 sel_word;

  function automatic way_t lowest_way(input logic [NUM_WAYS-1:0] vec);
    way_t way;
    way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (vec[w])
        way = way_t'(w);
    end
    return way;
  endfunction

  // take a request only when its response can be sent
  assign pop      = (state == IDLE) && head_valid && (resp_credits != '0);
  assign rd_index = head_addr[INDEX_LSB +: INDEX_W];

  assign req_tag   = req_addr_q[TAG_LSB +: TAG_W];
  assign req_index = req_addr_q[INDEX_LSB +: INDEX_W];
  assign word_sel  = req_addr_q[WORD_SEL_LSB +: WORD_SEL_W];

  // highest active way number: 0, 1, 3 or 7
  assign way_limit = way_t'((1 << req_ways_q) - 1);

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      hit_vec[w]  = (w <= int'(way_limit)) && tag_rd_valid[w] && (tag_rd_tags[w] == req_tag);
      free_vec[w] = (w <= int'(way_limit)) && !tag_rd_valid[w];
    end
  end

  assign hit        = |hit_vec;
  assign hit_way    = lowest_way(hit_vec);
  assign free_way   = lowest_way(free_vec);
  assign victim_way = (|free_vec) ? free_way : (rr_ptr & way_limit);
  assign sel_way    = hit ? hit_way : victim_way;

  // a fresh line is all zeros, a write then merges its word
  always_comb
  begin
    new_line = hit ? line_rd[sel_way] : '0;
    sel_word = '0;
    for (int i = 0; i < LINE_WORDS; i++)
    begin
      if (word_sel == WORD_SEL_W'(i))
      begin
        if (req_write_q)
          new_line[i*WORD_W +: WORD_W] = req_wdata_q;
        sel_word = new_line[i*WORD_W +: WORD_W];
      end
    end
  end

  assign tag_wr_en    = (state == LOOKUP) && !hit;
  assign tag_wr_way   = victim_way;
  assign tag_wr_index = req_index;
  assign tag_wr_tag   = req_tag;

  assign data_wr_en    = (state == LOOKUP) && (!hit || req_write_q);
  assign data_wr_way   = sel_way;
  assign data_wr_index = req_index;
  assign data_wr_line  = new_line;

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      state        <= IDLE;
      resp_valid   <= 1'b0;
      resp_credits <= RESP_CNT_W'(RESP_CREDITS);
      rr_ptr       <= '0;
      hit_count    <= '0;
      miss_count   <= '0;
    end
    else
    begin
      resp_valid <= (state == LOOKUP);
      case (state)
        IDLE:
        begin
          if (pop)
            state <= LOOKUP;
        end
        LOOKUP:
        begin
          state <= IDLE;
          if (hit)
            hit_count <= hit_count + COUNT_W'(1);
          else
            miss_count <= miss_count + COUNT_W'(1);
          // pointer moves only when it picked the victim
          if (!hit && !(|free_vec))
            rr_ptr <= rr_ptr + WAY_W'(1);
        end
        default: state <= IDLE;
      endcase
      if ((state == LOOKUP) && !resp_credit)
        resp_credits <= resp_credits - RESP_CNT_W'(1);
      else if ((state != LOOKUP) && resp_credit)
        resp_credits <= resp_credits + RESP_CNT_W'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      req_write_q <= head_write;
      req_ways_q  <= head_ways;
      req_addr_q  <= head_addr;
      req_wdata_q <= head_wdata;
    end
    if (state == LOOKUP)
    begin
      resp_hit   <= hit;
      resp_rdata <= sel_word;
    end
  end

endmodule

/* cache/cache_top.sv */
module cache_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  logic                 req_write,
  input  cache_pkg::way_mode_t req_ways,
  input  cache_pkg::addr_t     req_addr,
  input  cache_pkg::word_t     req_wdata,
  output logic                 req_credit,
  output logic                 resp_valid,
  output logic                 resp_hit,
  output cache_pkg::word_t     resp_rdata,
  input  logic                 resp_credit,
  output cache_pkg::count_t    hit_count,
  output cache_pkg::count_t    miss_count
);
  import cache_pkg::*;

  // queue head towards the controller
  logic      head_valid;
  logic      head_write;
  way_mode_t head_ways;
  addr_t     head_addr;
  word_t     head_wdata;
  logic      pop;

  // array read side
  index_t                    rd_index;
  logic [NUM_WAYS-1:0]       tag_rd_valid;
  tag_t [NUM_WAYS-1:0]       tag_rd_tags;
  line_t [NUM_WAYS-1:0]      line_rd;

  // array write side
  logic   tag_wr_en;
  way_t   tag_wr_way;
  index_t tag_wr_index;
  tag_t   tag_wr_tag;
  logic   data_wr_en;
  way_t   data_wr_way;
  index_t data_wr_index;
  line_t  data_wr_line;

  req_queue u_req_queue (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (req_valid),
    .in_write   (req_write),
    .in_ways    (req_ways),
    .in_addr    (req_addr),
    .in_wdata   (req_wdata),
    .pop        (pop),
    .head_valid (head_valid),
    .head_write (head_write),
    .head_ways  (head_ways),
    .head_addr  (head_addr),
    .head_wdata (head_wdata),
    .credit     (req_credit)
  );

  cache_ctrl u_cache_ctrl (
    .clk           (clk),
    .reset         (reset),
    .head_valid    (head_valid),
    .head_write    (head_write),
    .head_ways     (head_ways),
    .head_addr     (head_addr),
    .head_wdata    (head_wdata),
    .pop           (pop),
    .resp_credit   (resp_credit),
    .resp_valid    (resp_valid),
    .resp_hit      (resp_hit),
    .resp_rdata    (resp_rdata),
    .rd_index      (rd_index),
    .tag_rd_valid  (tag_rd_valid),
    .tag_rd_tags   (tag_rd_tags),
    .line_rd       (line_rd),
    .tag_wr_en     (tag_wr_en),
    .tag_wr_way    (tag_wr_way),
    .tag_wr_index  (tag_wr_index),
    .tag_wr_tag    (tag_wr_tag),
    .data_wr_en    (data_wr_en),
    .data_wr_way   (data_wr_way),
    .data_wr_index (data_wr_index),
    .data_wr_line  (data_wr_line),
    .hit_count     (hit_count),
    .miss_count    (miss_count)
  );

  tag_array u_tag_array (
    .clk      (clk),
    .reset    (reset),
    .rd_index (rd_index),
    .wr_en    (tag_wr_en),
    .wr_way   (tag_wr_way),
    .wr_index (tag_wr_index),
    .wr_tag   (tag_wr_tag),
    .rd_valid (tag_rd_valid),
    .rd_tags  (tag_rd_tags)
  );

  data_array u_data_array (
    .clk      (clk),
    .rd_index (rd_index),
    .wr_en    (data_wr_en),
    .wr_way   (data_wr_way),
    .wr_index (data_wr_index),
    .wr_line  (data_wr_line),
    .rd_lines (line_rd)
  );

endmodule

/* verif/clock_gen.sv */
module clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // active low, released on a falling edge
  initial
  begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
  end

endmodule

/* verif/cache_checker.sv */
module cache_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  logic                 req_write,
  input  cache_pkg::way_mode_t req_ways,
  input  cache_pkg::addr_t     req_addr,
  input  cache_pkg::word_t     req_wdata,
  input  logic                 req_credit,
  input  logic                 resp_valid,
  input  logic                 resp_hit,
  input  cache_pkg::word_t     resp_rdata,
  input  logic                 resp_credit,
  input  cache_pkg::count_t    hit_count,
  input  cache_pkg::count_t    miss_count,
  output int                   error_count,
  output int                   resp_count
);
  import cache_pkg::*;

  // accepted requests still waiting for their response
  logic      q_write [$];
  way_mode_t q_ways  [$];
  addr_t     q_addr  [$];
  word_t     q_wdata [$];

  // reference cache contents
  logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
  tag_t                m_tag   [NUM_SETS][NUM_WAYS];
  word_t               m_data  [NUM_SETS][NUM_WAYS][4];
  way_t                m_rr;
  count_t              m_hits;
  count_t              m_misses;

  int    resp_credits;
  int    accepted;
  int    credits_back;
  logic  exp_hit;
  word_t exp_data;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      error_count++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report(input string what);
    error_count++;
    $display("at %0t: %s", $time, what);
  endtask

  // lowest matching active way hits, else lowest invalid active way, else masked pointer
  task automatic model_access(input logic write, input way_mode_t ways, input addr_t addr,
                              input word_t wdata, output logic hit, output word_t rdata);
    int   n;
    int   idx;
    int   wsel;
    int   way;
    tag_t tag;
    n    = 1 << int'(ways);
    tag  = addr[31:10];
    idx  = int'(addr[9:4]);
    wsel = int'(addr[3:2]);
    hit  = 1'b0;
    way  = -1;
    for (int w = n - 1; w >= 0; w--)
    begin
      if (m_valid[idx][w] && (m_tag[idx][w] == tag))
      begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit)
    begin
      for (int w = n - 1; w >= 0; w--)
      begin
        if (!m_valid[idx][w])
          way = w;
      end
      if (way < 0)
      begin
        way  = int'(m_rr) % n;
        m_rr = m_rr + 3'd1;
      end
      m_valid[idx][way] = 1'b1;
      m_tag[idx][way]   = tag;
      for (int k = 0; k < 4; k++)
        m_data[idx][way][k] = '0;
      m_misses = m_misses + 16'd1;
    end
    else
      m_hits = m_hits + 16'd1;
    if (write)
      m_data[idx][way][wsel] = wdata;
    rdata = m_data[idx][way][wsel];
  endtask

  always @(posedge clk)
  begin
    if (!reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
        m_valid[s] = '0;
      m_rr         = '0;
      m_hits       = '0;
      m_misses     = '0;
      resp_credits = RESP_CREDITS;
      accepted     = 0;
      credits_back = 0;
      error_count  = 0;
      resp_count   = 0;
      q_write.delete();
      q_ways.delete();
      q_addr.delete();
      q_wdata.delete();
    end
    else
    begin
      if (req_valid)
      begin
        accepted++;
        q_write.push_back(req_write);
        q_ways.push_back(req_ways);
        q_addr.push_back(req_addr);
        q_wdata.push_back(req_wdata);
      end
      if (req_credit)
      begin
        credits_back++;
        if (credits_back > accepted)
          report("req_credit returned more credits than requests were accepted");
      end
      if (resp_credit)
        resp_credits++;
      if (resp_valid)
      begin
        resp_count++;
        if (resp_credits == 0)
          report("resp_valid was raised while the cache held no response credit");
        else
          resp_credits--;
        if (q_addr.size() == 0)
          report("a response arrived with no request outstanding");
        else
        begin
          model_access(q_write.pop_front(), q_ways.pop_front(), q_addr.pop_front(),
                       q_wdata.pop_front(), exp_hit, exp_data);
          check_value("resp_hit", 32'(exp_hit), 32'(resp_hit));
          check_value("resp_rdata", exp_data, resp_rdata);
          check_value("hit_count", 32'(m_hits), 32'(hit_count));
          check_value("miss_count", 32'(m_misses), 32'(miss_count));
        end
      end
    end
  end

endmodule

/* verif/tb_top.sv */
module tb_top;
  import cache_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_DIRECTED    = 26;
  localparam int NUM_RANDOM      = 400;
  localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 12;

  logic      clk;
  logic      reset;
  logic      req_valid;
  logic      req_write;
  way_mode_t req_ways;
  addr_t     req_addr;
  word_t     req_wdata;
  logic      req_credit;
  logic      resp_valid;
  logic      resp_hit;
  word_t     resp_rdata;
  logic      resp_credit;
  count_t    hit_count;
  count_t    miss_count;

  int error_count;
  int resp_count;
  int req_credits;
  int resp_owed;
  int sent;

  clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  cache_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_ways    (req_ways),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_rdata  (resp_rdata),
    .resp_credit (resp_credit),
    .hit_count   (hit_count),
    .miss_count  (miss_count)
  );

  cache_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_ways    (req_ways),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_rdata  (resp_rdata),
    .resp_credit (resp_credit),
    .hit_count   (hit_count),
    .miss_count  (miss_count),
    .error_count (error_count),
    .resp_count  (resp_count)
  );

  // credits held by the requester
  always @(posedge clk)
  begin
    if (!reset)
      req_credits <= REQ_DEPTH;
    else
      req_credits <= req_credits + (req_credit ? 1 : 0) - (req_valid ? 1 : 0);
  end

  // responses received but not yet paid back
  always @(posedge clk)
  begin
    if (!reset)
      resp_owed <= 0;
    else
      resp_owed <= resp_owed + (resp_valid ? 1 : 0) - (resp_credit ? 1 : 0);
  end

  // consumer holds back credits now and then
  initial
  begin
    resp_credit = 1'b0;
    forever
    begin
      @(negedge clk);
      resp_credit = reset && (resp_owed > 0) && ($urandom_range(0, 2) != 0);
    end
  end

  function automatic addr_t make_addr(input int tag, input int index, input int word);
    return {tag_t'(tag), index_t'(index), 2'(word), 2'b00};
  endfunction

  task automatic send_req(input logic write, input way_mode_t ways, input addr_t addr,
                          input word_t wdata);
    while (req_credits == 0)
      @(negedge clk);
    req_valid = 1'b1;
    req_write = write;
    req_ways  = ways;
    req_addr  = addr;
    req_wdata = wdata;
    @(negedge clk);
    req_valid = 1'b0;
    sent++;
  endtask

  initial
  begin
    void'($urandom(32'h0c021d77));
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_ways    = '0;
    req_addr    = '0;
    req_wdata   = '0;
    sent        = 0;
    wait (reset === 1'b1);
    @(negedge clk);
    // read miss gives zero and the same read then hits
    send_req(1'b0, 2'd3, make_addr(32'h40, 1, 0), '0);
    send_req(1'b0, 2'd3, make_addr(32'h40, 1, 0), '0);
    // one written word while the rest of the line stays zero
    send_req(1'b1, 2'd3, make_addr(32'h41, 2, 1), 32'hcafe0001);
    for (int w = 0; w < 4; w++)
      send_req(1'b0, 2'd3, make_addr(32'h41, 2, w), '0);
    // eight tags in one set all stay resident
    for (int t = 0; t < 8; t++)
      send_req(1'b0, 2'd3, make_addr(32'h80 + t, 5, 0), '0);
    for (int t = 0; t < 8; t++)
      send_req(1'b0, 2'd3, make_addr(32'h80 + t, 5, 0), '0);
    // in direct mapped mode a second tag pushes out the first
    send_req(1'b0, 2'd0, make_addr(32'h90, 6, 0), '0);
    send_req(1'b0, 2'd0, make_addr(32'h91, 6, 0), '0);
    send_req(1'b0, 2'd0, make_addr(32'h90, 6, 0), '0);
    // small tag and index pool keeps the sets under pressure
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      if ($urandom_range(0, 3) == 0)
        @(negedge clk);
      send_req(1'($urandom_range(0, 1)), way_mode_t'($urandom_range(0, 3)),
               make_addr(32'h100 + $urandom_range(0, 11), $urandom_range(0, 3),
                         $urandom_range(0, 3)), $urandom());
    end
    wait (resp_count == sent);
    repeat (2) @(negedge clk);
    $display("done: %0d requests, %0d responses, %0d errors", sent, resp_count, error_count);
    if (error_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: only %0d of %0d responses arrived, %0d errors so far",
             resp_count, NUM_DIRECTED + NUM_RANDOM, error_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* assoc_cache.f */
common/cache_pkg.sv
logic/req_queue.sv
cache/tag_array.sv
cache/data_array.sv
cache/cache_ctrl.sv
cache/cache_top.sv
verif/clock_gen.sv
verif/cache_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f assoc_cache.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx 'RESULT: PASS'; then
  exit 0
else
  exit 1
fi
